// File: src.f
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/line_buffer.sv
verilog/insn_decoder.sv
verilog/perf_counters.sv
verilog/fetch_top.sv
verification/fetch_asserts.sv
verification/fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fetch_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a nonzero exit, e.g. a bound assertion, also counts as failure
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || echo "Testbench failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  import fetch_pkg::*;

  // line aligned boot address
  localparam logic [31:0] RESET_PC    = 32'h0001_0040;
  localparam int          CREDITS     = 4;
  localparam int          ADDR_W      = 26;
  localparam int          N_INSN      = 400;
  localparam int          WATCHDOG_NS = (N_INSN * 4 + 200) * 20;
  // widest value an error line shows
  localparam int          VAL_W       = $bits(dec_insn_t);

  logic              clk = 1'b0;
  logic              rst;
  logic              avl_read_req;
  logic [ADDR_W-1:0] avl_addr;
  logic              avl_ready;
  logic              avl_rdata_valid;
  logic [LINE_W-1:0] avl_rdata;
  logic              dec_valid;
  dec_insn_t         dec;
  logic              credit_return;
  perf_cnt_t         perf;

  // scoreboard state
  logic              running = 1'b0;
  logic              line_pending = 1'b0;
  logic [ADDR_W-1:0] req_addr;
  logic [31:0]       next_pc = RESET_PC;
  dec_insn_t         exp_dec;
  int                beats = 0;
  int                credits_ret = 0;
  int                cyc_seen = 0;
  int                hold = 0;

  fetch_top #(
    .RESET_PC (RESET_PC),
    .CREDITS  (CREDITS),
    .ADDR_W   (ADDR_W)
  ) fetch_top_i (
    .clk             (clk),
    .rst             (rst),
    .avl_read_req    (avl_read_req),
    .avl_addr        (avl_addr),
    .avl_ready       (avl_ready),
    .avl_rdata_valid (avl_rdata_valid),
    .avl_rdata       (avl_rdata),
    .dec_valid       (dec_valid),
    .dec             (dec),
    .credit_return   (credit_return),
    .perf            (perf)
  );

  always #10 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [VAL_W-1:0] exp,
                                 input logic [VAL_W-1:0] act);
    $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    $display("Testbench failed");
    $fatal(1, "check %s failed", name);
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] %s", what);
    $display("Testbench failed");
    $fatal(1, "%s", what);
  endtask

  // memory image, one encoding per n mod 8
  function automatic logic [31:0] mem_word(input logic [31:0] n);
    logic [4:0]  r;
    logic [31:0] h;
    logic [31:0] w;
    r = n[4:0];
    // spread the address over the immediate bits
    h = n * 32'h9e37_79b9;
    case (n[2:0])
      3'd0: w = {h[31:25], r, r, 3'b000, r, 7'b0110011};
      3'd1: w = {h[31:20], r, 3'b000, r, 7'b0010011};
      3'd2: w = {h[31:25], r, r, 3'b010, h[11:7], 7'b0100011};
      3'd3: w = {h[31:25], r, r, 3'b001, h[11:7], 7'b1100011};
      3'd4: w = {h[31:12], r, 7'b0110111};
      3'd5: w = {h[31:12], r, 7'b1101111};
      3'd6: w = {h[31:20], r, 3'b010, r, 7'b0000011};
      // opcode outside rv32i
      default: w = {h[31:25], r, r, 3'b000, r, 7'b1111111};
    endcase
    return w;
  endfunction

  function automatic logic [LINE_W-1:0] mem_line(input logic [ADDR_W-1:0] line_addr);
    logic [LINE_W-1:0] l;
    for (int i = 0; i < WORDS_PER_LINE; i++)
      l[i*WORD_W +: WORD_W] = mem_word(32'({line_addr, 2'b00}) + 32'(i));
    return l;
  endfunction

  // expected decode straight from the rv32i bit layout
  function automatic dec_insn_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
    dec_insn_t d;
    d.pc     = pc;
    d.raw    = w;
    d.opcode = w[6:0];
    d.rd     = w[11:7];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.funct3 = w[14:12];
    d.funct7 = w[31:25];
    case (w[6:0])
      7'h37, 7'h17:                      d.fmt = FMT_U;
      7'h6f:                             d.fmt = FMT_J;
      7'h67, 7'h03, 7'h13, 7'h0f, 7'h73: d.fmt = FMT_I;
      7'h23:                             d.fmt = FMT_S;
      7'h63:                             d.fmt = FMT_B;
      7'h33:                             d.fmt = FMT_R;
      default:                           d.fmt = FMT_BAD;
    endcase
    case (d.fmt)
      FMT_I:   d.imm = {{21{w[31]}}, w[30:20]};
      FMT_S:   d.imm = {{21{w[31]}}, w[30:25], w[11:7]};
      FMT_B:   d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      FMT_U:   d.imm = {w[31:12], 12'h000};
      FMT_J:   d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  // request held until taken, single line in flight
  assert property (@(posedge clk) disable iff (rst)
    (avl_read_req && !avl_ready) |=> (avl_read_req && $stable(avl_addr)))
    else report_failure("avl_read_req or avl_addr changed before avl_ready");

  assert property (@(posedge clk) disable iff (rst) line_pending |-> !avl_read_req)
    else report_failure("new line request while a line was still outstanding");

  // memory model, random ready delay then 1 to 8 cycle return
  initial
  begin
    avl_ready       = 1'b0;
    avl_rdata_valid = 1'b0;
    avl_rdata       = '0;
    forever
    begin
      @(posedge clk);
      #1;
      if (!rst && avl_read_req)
      begin
        repeat ($urandom_range(0, 2))
        begin
          @(posedge clk);
          #1;
        end
        avl_ready = 1'b1;
        req_addr  = avl_addr;
        @(posedge clk);
        #1;
        avl_ready    = 1'b0;
        line_pending = 1'b1;
        repeat ($urandom_range(0, 7))
        begin
          @(posedge clk);
          #1;
        end
        avl_rdata       = mem_line(req_addr);
        avl_rdata_valid = 1'b1;
        @(posedge clk);
        #1;
        avl_rdata_valid = 1'b0;
        line_pending    = 1'b0;
      end
    end
  end

  // consumer, one credit per received beat
  initial
  begin
    credit_return = 1'b0;
    forever
    begin
      @(posedge clk);
      // the dut took this pulse at the edge
      if (credit_return)
        credits_ret++;
      #1;
      credit_return = 1'b0;
      if (running)
      begin
        // occasional stall so the pool runs dry
        if (hold > 0)
          hold--;
        else if ($urandom_range(0, 39) == 0)
          hold = $urandom_range(4, 10);
        else if (beats > credits_ret && $urandom_range(0, 3) != 0)
          credit_return = 1'b1;
      end
    end
  end

  // output monitor, sampled mid cycle
  always @(negedge clk)
  begin
    if (running)
    begin
      assert (perf.cycles == 64'(cyc_seen))
        else report_mismatch("cycles", VAL_W'(cyc_seen), VAL_W'(perf.cycles));
      // instret lags dec_valid by one cycle
      assert (perf.instret == 64'(beats))
        else report_mismatch("instret", VAL_W'(beats), VAL_W'(perf.instret));
      cyc_seen++;
      if (dec_valid)
      begin
        assert (dec.pc == next_pc)
          else report_mismatch("pc_order", VAL_W'(next_pc), VAL_W'(dec.pc));
        exp_dec = ref_decode(mem_word(next_pc >> 2), next_pc);
        assert (dec == exp_dec)
          else report_mismatch("decode", exp_dec, dec);
        next_pc = next_pc + 32'd4;
        beats++;
        assert (beats - credits_ret <= CREDITS)
          else report_mismatch("credits", VAL_W'(CREDITS), VAL_W'(beats - credits_ret));
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("[ERROR] watchdog expired with %0d of %0d instructions seen", beats, N_INSN);
    $display("Testbench failed");
    $fatal(1, "watchdog timeout");
  end

  initial
  begin
    void'($urandom(32'h5020_aa35));
    rst = 1'b1;
    repeat (16)
    begin
      @(posedge clk);
      #1;
      assert (!avl_read_req && !dec_valid && perf == '0)
        else report_failure("request, dec_valid or counters not zero during reset");
    end
    rst     = 1'b0;
    running = 1'b1;
    // boot line requested right away
    @(posedge clk);
    #1;
    assert (avl_read_req)
      else report_failure("no line request in the first cycle after reset");
    assert (avl_addr == ADDR_W'(RESET_PC >> 4))
      else report_mismatch("first_req_addr", VAL_W'(RESET_PC >> 4), VAL_W'(avl_addr));
    wait (beats >= N_INSN);
    repeat (2) @(negedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/fetch_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_asserts #(
  parameter int CREDITS = 4,
  parameter int ADDR_W  = 26
) (
  input wire logic                           clk,
  input wire logic                           rst,
  input wire logic                           avl_read_req,
  input wire logic [ADDR_W-1:0]              avl_addr,
  input wire logic                           avl_ready,
  input wire logic                           issue,
  input wire logic                           credit_return,
  input wire logic [$clog2(CREDITS + 1)-1:0] credit_cnt
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  // words handed out and not yet paid back
  int outstanding;

  always_ff @(posedge clk)
  begin
    if (rst)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(issue) - int'(credit_return);
  end

  // pool never grows past its reset size
  credit_bound: assert property (
    @(posedge clk) disable iff (rst)
    credit_cnt <= CNT_W'(CREDITS))
    else $error("credit count %0d above limit %0d", credit_cnt, CREDITS);

  // an issue needs a credit that was never spent
  issue_needs_credit: assert property (
    @(posedge clk) disable iff (rst)
    issue |-> (outstanding < CREDITS))
    else $error("issue with %0d words already outstanding", outstanding);

  // avalon request held steady until taken
  req_held: assert property (
    @(posedge clk) disable iff (rst)
    (avl_read_req && !avl_ready) |=> (avl_read_req && $stable(avl_addr)))
    else $error("avl_read_req or avl_addr moved before avl_ready");

endmodule

// watch the controller from inside
bind fetch_ctrl fetch_asserts #(
  .CREDITS (CREDITS),
  .ADDR_W  (ADDR_W)
) fetch_asserts_i (
  .clk           (clk),
  .rst           (rst),
  .avl_read_req  (avl_read_req),
  .avl_addr      (avl_addr),
  .avl_ready     (avl_ready),
  .issue         (issue),
  .credit_return (credit_return),
  .credit_cnt    (credit_cnt)
);

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000,
  parameter int          CREDITS  = 4,
  parameter int          ADDR_W   = 26
) (
  input  wire logic                         clk,
  input  wire logic                         rst,
  // avalon line port
  output      logic                         avl_read_req,
  output      logic [ADDR_W-1:0]            avl_addr,
  input  wire logic                         avl_ready,
  input  wire logic                         avl_rdata_valid,
  input  wire logic [fetch_pkg::LINE_W-1:0] avl_rdata,
  // decoded stream, credit flow control
  output      logic                         dec_valid,
  output      fetch_pkg::dec_insn_t         dec,
  input  wire logic                         credit_return,
  output      fetch_pkg::perf_cnt_t         perf
);

  import fetch_pkg::*;

  logic              line_load;
  logic [1:0]        word_sel;
  logic              issue;
  logic [WORD_W-1:0] word;
  logic [31:0]       word_pc;

  // request side, word pointer, credits
  fetch_ctrl #(
    .RESET_PC (RESET_PC),
    .CREDITS  (CREDITS),
    .ADDR_W   (ADDR_W)
  ) fetch_ctrl_i (
    .clk             (clk),
    .rst             (rst),
    .avl_ready       (avl_ready),
    .avl_rdata_valid (avl_rdata_valid),
    .credit_return   (credit_return),
    .avl_read_req    (avl_read_req),
    .avl_addr        (avl_addr),
    .line_load       (line_load),
    .word_sel        (word_sel),
    .issue           (issue)
  );

  // request address doubles as the captured line address
  line_buffer #(
    .ADDR_W (ADDR_W)
  ) line_buffer_i (
    .clk       (clk),
    .rst       (rst),
    .line_load (line_load),
    .avl_rdata (avl_rdata),
    .line_addr (avl_addr),
    .word_sel  (word_sel),
    .word      (word),
    .word_pc   (word_pc)
  );

  insn_decoder insn_decoder_i (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .word      (word),
    .word_pc   (word_pc),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  perf_counters perf_counters_i (
    .clk       (clk),
    .rst       (rst),
    .dec_valid (dec_valid),
    .perf      (perf)
  );

endmodule

`default_nettype wire

// File: verilog/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             dec_valid,
  output      fetch_pkg::perf_cnt_t perf
);

  import fetch_pkg::*;

  // mcycle, free running once out of reset
  always_ff @(posedge clk)
  begin
    if (rst)
      perf.cycles <= '0;
    else
      perf.cycles <= perf.cycles + 64'd1;
  end

  // minstret, one per decoded beat
  // shows up the cycle after the beat
  always_ff @(posedge clk)
  begin
    if (rst)
      perf.instret <= '0;
    else if (dec_valid)
      perf.instret <= perf.instret + 64'd1;
  end

endmodule

`default_nettype wire

// File: verilog/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         issue,
  input  wire logic [fetch_pkg::WORD_W-1:0] word,
  input  wire logic [31:0]                  word_pc,
  output      logic                         dec_valid,
  output      fetch_pkg::dec_insn_t         dec
);

  import fetch_pkg::*;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  insn_word_u iw;
  insn_fmt_e  fmt;
  logic [31:0] imm;

  assign iw = word;

  // format from opcode only
  always_comb
  begin
    case (iw.r_fmt.opcode)
      OPC_LUI, OPC_AUIPC:
        fmt = FMT_U;
      OPC_JAL:
        fmt = FMT_J;
      OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_FENCE, OPC_SYSTEM:
        fmt = FMT_I;
      OPC_STORE:
        fmt = FMT_S;
      OPC_BRANCH:
        fmt = FMT_B;
      OPC_OP:
        fmt = FMT_R;
      default:
        fmt = FMT_BAD;
    endcase
  end

  // immediate per format, sign always from word bit 31
  always_comb
  begin
    case (fmt)
      FMT_I:
        imm = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
      FMT_S:
        imm = {{20{iw.s_fmt.imm_11_5[6]}}, iw.s_fmt.imm_11_5, iw.s_fmt.imm_4_0};
      FMT_B:
        imm = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
               iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
      // upper 20 bits, low 12 zero
      FMT_U:
        imm = {iw.u_fmt.imm_31_12, 12'h000};
      FMT_J:
        imm = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
               iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};
      // R and bad carry no immediate
      default:
        imm = '0;
    endcase
  end

  // valid flag
  always_ff @(posedge clk)
  begin
    if (rst)
      dec_valid <= 1'b0;
    else
      dec_valid <= issue;
  end

  // payload, loaded only on issue
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      dec.pc     <= word_pc;
      dec.raw    <= word;
      dec.fmt    <= fmt;
      dec.opcode <= iw.r_fmt.opcode;
      // register and funct fields straight from the bits
      dec.rd     <= iw.r_fmt.rd;
      dec.rs1    <= iw.r_fmt.rs1;
      dec.rs2    <= iw.r_fmt.rs2;
      dec.funct3 <= iw.r_fmt.funct3;
      dec.funct7 <= iw.r_fmt.funct7;
      dec.imm    <= imm;
    end
  end

endmodule

`default_nettype wire

// File: verilog/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
  parameter int ADDR_W = 26
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        line_load,
  input  wire logic [fetch_pkg::LINE_W-1:0] avl_rdata,
  input  wire logic [ADDR_W-1:0]           line_addr,
  input  wire logic [1:0]                  word_sel,
  output      logic [fetch_pkg::WORD_W-1:0] word,
  output      logic [31:0]                 word_pc
);

  import fetch_pkg::*;

  // line held as words, word 0 in the low bits
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_q;
  logic [ADDR_W-1:0]                     addr_q;

  // data array
  always_ff @(posedge clk)
  begin
    if (line_load)
      line_q <= avl_rdata;
  end

  // line address follows the data
  always_ff @(posedge clk)
  begin
    if (rst)
      addr_q <= '0;
    else if (line_load)
      addr_q <= line_addr;
  end

  // current word
  assign word = line_q[word_sel];

  // byte pc = line, word index, 2 zero bits
  assign word_pc = 32'({addr_q, word_sel, 2'b00});

endmodule

`default_nettype wire

// File: verilog/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000,
  parameter int          CREDITS  = 4,
  parameter int          ADDR_W   = 26
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              avl_ready,
  input  wire logic              avl_rdata_valid,
  input  wire logic              credit_return,
  output      logic              avl_read_req,
  output      logic [ADDR_W-1:0] avl_addr,
  output      logic              line_load,
  output      logic [1:0]        word_sel,
  output      logic              issue
);

  import fetch_pkg::*;

  // wide enough to hold CREDITS itself
  localparam int CNT_W = $clog2(CREDITS + 1);

  typedef enum logic [1:0] {
    REQ,
    WAIT,
    ISSUE
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] credit_cnt;
  logic             last_word;

  // line arrives only while waiting for it
  assign line_load = (state == WAIT) && avl_rdata_valid;

  // one word per cycle while a credit is free
  assign issue = (state == ISSUE) && (credit_cnt != '0);

  assign last_word = (word_sel == 2'(WORDS_PER_LINE - 1));

  // request, line address and word pointer
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= REQ;
      avl_read_req <= 1'b0;
      // boot line, byte address over 16
      avl_addr     <= ADDR_W'(RESET_PC >> 4);
      word_sel     <= '0;
    end
    else
    begin
      case (state)
        REQ:
        begin
          // hold req and addr until the port takes it
          if (avl_read_req && avl_ready)
          begin
            avl_read_req <= 1'b0;
            state        <= WAIT;
          end
          else
            avl_read_req <= 1'b1;
        end
        WAIT:
        begin
          if (avl_rdata_valid)
          begin
            word_sel <= '0;
            state    <= ISSUE;
          end
        end
        ISSUE:
        begin
          if (issue)
          begin
            word_sel <= word_sel + 2'd1;
            // last word out, next sequential line
            if (last_word)
            begin
              avl_addr     <= avl_addr + ADDR_W'(1);
              avl_read_req <= 1'b1;
              state        <= REQ;
            end
          end
        end
        default:
          state <= REQ;
      endcase
    end
  end

  // credit pool, spend and return in the same cycle cancel
  always_ff @(posedge clk)
  begin
    if (rst)
      credit_cnt <= CNT_W'(CREDITS);
    else if (issue && !credit_return)
      credit_cnt <= credit_cnt - CNT_W'(1);
    else if (!issue && credit_return)
      credit_cnt <= credit_cnt + CNT_W'(1);
  end

endmodule

`default_nettype wire

// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // memory line and instruction word geometry
  localparam int LINE_W         = 128;
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;

  // rv32i encoding formats, FMT_BAD for unknown opcodes
  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_BAD
  } insn_fmt_e;

  // register-register ops
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // immediates, loads, jalr, fence, system
  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // stores
  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // branches, imm bit 0 implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // lui / auipc
  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // jal, scrambled 20 bit offset
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one 32 bit word, six views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_word_u;

  // decoder output beat
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] raw;
    insn_fmt_e   fmt;
    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;
  } dec_insn_t;

  // mcycle / minstret pair
  typedef struct packed {
    logic [63:0] cycles;
    logic [63:0] instret;
  } perf_cnt_t;

endpackage

`default_nettype wire
